//--- hdl/cache_be_config.svh
`ifndef CACHE_BE_CONFIG_SVH
`define CACHE_BE_CONFIG_SVH

// Front-end side, byte addressed.
`define CACHE_FE_ADDR_W 24
`define CACHE_FE_DATA_W 32

// Memory bus side.
`define CACHE_BE_ADDR_W 24
`define CACHE_BE_DATA_W 64

`define CACHE_WORD_OFFSET_W 3 // Words per line, log2.

`define CACHE_FE_NBYTES (`CACHE_FE_DATA_W / 8)
`define CACHE_FE_NBYTES_W $clog2(`CACHE_FE_NBYTES)
`define CACHE_BE_NBYTES (`CACHE_BE_DATA_W / 8)
`define CACHE_BE_NBYTES_W $clog2(`CACHE_BE_NBYTES)

// Front-end words packed in one beat.
`define CACHE_BE_WORDS (`CACHE_BE_DATA_W / `CACHE_FE_DATA_W)
`define CACHE_BE_WORDS_W $clog2(`CACHE_BE_WORDS)

// Beats per line, log2.
`define CACHE_LINE2BE_W (`CACHE_WORD_OFFSET_W - `CACHE_BE_WORDS_W)

`endif

//--- hdl/cache_fe_pkg.sv
`include "cache_be_config.svh"

package cache_fe_pkg;

   // One word as seen by the cache controller.
   typedef logic [`CACHE_FE_DATA_W-1:0] fe_word_t;

   typedef logic [`CACHE_FE_NBYTES-1:0] fe_strb_t; // One bit per byte.

   // Word address, byte offset dropped.
   typedef logic [`CACHE_FE_ADDR_W-`CACHE_FE_NBYTES_W-1:0] fe_waddr_t;

   // Line address, beat and byte offsets dropped.
   typedef logic [`CACHE_FE_ADDR_W-`CACHE_BE_NBYTES_W-`CACHE_LINE2BE_W-1:0]
      line_addr_t;

   typedef logic [`CACHE_LINE2BE_W-1:0] beat_idx_t; // Beat within a line.

endpackage

//--- hdl/cache_bus_pkg.sv
`include "cache_be_config.svh"

package cache_bus_pkg;

   import cache_fe_pkg::*;

   typedef logic [`CACHE_BE_DATA_W-1:0] be_data_t;
   typedef logic [`CACHE_BE_NBYTES-1:0] be_strb_t;

   // Field view of a bus address, most significant first.
   typedef struct packed {
      line_addr_t                        line;
      beat_idx_t                         beat;
      logic [`CACHE_BE_WORDS_W-1:0]      word_in_beat; // Word lane in the beat.
      logic [`CACHE_FE_NBYTES_W-1:0]     byte_off;
   } be_addr_fields_t;

   // Same address word, flat for the bus or split for the channels.
   typedef union packed {
      logic [`CACHE_BE_ADDR_W-1:0] flat;
      be_addr_fields_t             f;
   } be_addr_u;

endpackage

//--- hdl/be_bus_if.sv
`timescale 1ns/1ns

interface be_bus_if
   import cache_bus_pkg::*;
();

   logic     valid;
   be_addr_u addr;
   be_data_t wdata;
   be_strb_t wstrb;
   be_data_t rdata;
   logic     ready; // Last cycle of the transfer.

   modport requester (
      output valid,
      output addr,
      output wdata,
      output wstrb,
      input  rdata,
      input  ready
   );

   modport arbiter (
      input  valid,
      input  addr,
      input  wdata,
      input  wstrb,
      output rdata,
      output ready
   );

endinterface

//--- hdl/cache_write_channel.sv
`timescale 1ns/1ns

`include "cache_be_config.svh"

module cache_write_channel
   import cache_fe_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n,

   input  logic      valid,
   input  fe_waddr_t addr,
   input  fe_word_t  wdata,
   input  fe_strb_t  wstrb,
   output logic      ready,

   be_bus_if.requester bus
);

   logic     busy;
   be_addr_u addr_q;
   be_data_t wdata_q;
   fe_strb_t strb_q;
   be_strb_t wstrb_lanes;

   // Idle until a store is taken, busy until the bus accepts it.
   always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
         busy <= 1'b0;
      end else if (!busy) begin
         busy <= valid;
      end else if (bus.ready) begin
         busy <= 1'b0;
      end
   end

   // Capture the store on acceptance.
   always_ff @(posedge clk_i) begin
      if (valid && !busy) begin
         addr_q.f.line         <= addr[$bits(fe_waddr_t)-1 -: $bits(line_addr_t)];
         addr_q.f.beat         <= addr[`CACHE_BE_WORDS_W +: `CACHE_LINE2BE_W];
         addr_q.f.word_in_beat <= addr[`CACHE_BE_WORDS_W-1:0];
         addr_q.f.byte_off     <= '0;
         wdata_q               <= {`CACHE_BE_WORDS{wdata}}; // Same word in every lane.
         strb_q                <= wstrb;
      end
   end

   // Only the addressed lane gets the strobes.
   always_comb begin
      wstrb_lanes = '0;
      for (int w = 0; w < `CACHE_BE_WORDS; w++) begin
         if (int'(addr_q.f.word_in_beat) == w)
            wstrb_lanes[w*`CACHE_FE_NBYTES +: `CACHE_FE_NBYTES] = strb_q;
      end
   end

   assign ready     = !busy;
   assign bus.valid = busy;
   assign bus.addr  = addr_q;
   assign bus.wdata = wdata_q;
   assign bus.wstrb = wstrb_lanes;

   // The front end must not change a store it is still offering.
   assert property (@(posedge clk_i) disable iff (!arst_n)
      (valid && !ready) |-> ($stable(addr) && $stable(wdata) && $stable(wstrb)))
      else $error("write request changed while not ready");

endmodule

//--- hdl/cache_read_channel.sv
`timescale 1ns/1ns

module cache_read_channel
   import cache_fe_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n,

   input  logic       replace_valid,
   input  line_addr_t replace_addr,
   output logic       replace,
   output logic       read_valid,
   output beat_idx_t  read_addr,
   output be_data_t   read_rdata,

   be_bus_if.requester bus
);

   line_addr_t line_q;
   beat_idx_t  beat_q;
   be_addr_u   req_addr;
   logic       beat_done;

   assign beat_done = replace && bus.ready;

   // Refill control. The beat counter wraps after the last beat.
   always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
         replace    <= 1'b0;
         read_valid <= 1'b0;
         beat_q     <= '0;
      end else begin
         read_valid <= beat_done; // One pulse per returned beat.
         if (!replace && replace_valid) begin
            replace <= 1'b1;
            beat_q  <= '0;
         end else if (beat_done) begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == '1)
               replace <= 1'b0; // Last beat ends the refill.
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!replace && replace_valid)
         line_q <= replace_addr;
   end

   // Returned beat and its index for the line store.
   always_ff @(posedge clk_i) begin
      if (beat_done) begin
         read_addr  <= beat_q;
         read_rdata <= bus.rdata;
      end
   end

   always_comb begin
      req_addr                = '0;
      req_addr.f.line         = line_q;
      req_addr.f.beat         = beat_q;
   end

   assign bus.valid = replace;
   assign bus.addr  = req_addr;
   assign bus.wdata = '0; // Reads only.
   assign bus.wstrb = '0;

   // Refill stays up for every beat but the last one handed over.
   assert property (@(posedge clk_i) disable iff (!arst_n)
      read_valid |-> (replace == (read_addr != '1)))
      else $error("replace out of step with the beat handed over");

   // Beat request holds until the bus takes it.
   assert property (@(posedge clk_i) disable iff (!arst_n)
      (bus.valid && !bus.ready) |=> (bus.valid && $stable(bus.addr)))
      else $error("beat request dropped or changed before ready");

endmodule

//--- hdl/cache_back_end.sv
`timescale 1ns/1ns

`include "cache_be_config.svh"

module cache_back_end
   import cache_fe_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        arst_n,

   // Write-through stores.
   input  logic                        write_valid,
   input  fe_waddr_t                   write_addr,
   input  fe_word_t                    write_wdata,
   input  fe_strb_t                    write_wstrb,
   output logic                        write_ready,

   // Line refill.
   input  logic                        replace_valid,
   input  line_addr_t                  replace_addr,
   output logic                        replace,
   output logic                        read_valid,
   output beat_idx_t                   read_addr,
   output be_data_t                    read_rdata,

   // Memory bus.
   output logic                        be_valid,
   output logic [`CACHE_BE_ADDR_W-1:0] be_addr,
   output be_data_t                    be_wdata,
   output be_strb_t                    be_wstrb,
   input  be_data_t                    be_rdata,
   input  logic                        be_ready
);

   logic rd_grant;

   be_bus_if rd_bus ();
   be_bus_if wr_bus ();

   cache_write_channel wr_chan (
      .clk_i (clk_i),
      .arst_n(arst_n),
      .valid (write_valid),
      .addr  (write_addr),
      .wdata (write_wdata),
      .wstrb (write_wstrb),
      .ready (write_ready),
      .bus   (wr_bus.requester)
   );

   cache_read_channel rd_chan (
      .clk_i        (clk_i),
      .arst_n       (arst_n),
      .replace_valid(replace_valid),
      .replace_addr (replace_addr),
      .replace      (replace),
      .read_valid   (read_valid),
      .read_addr    (read_addr),
      .read_rdata   (read_rdata),
      .bus          (rd_bus.requester)
   );

   assign rd_grant = rd_bus.valid; // Refill always wins.

   assign be_valid = rd_bus.valid || wr_bus.valid;
   assign be_addr  = rd_grant ? rd_bus.addr.flat : wr_bus.addr.flat;
   assign be_wdata = rd_grant ? rd_bus.wdata : wr_bus.wdata;
   assign be_wstrb = rd_grant ? rd_bus.wstrb : wr_bus.wstrb;

   assign rd_bus.ready = be_ready && rd_grant;
   assign rd_bus.rdata = rd_grant ? be_rdata : '0;
   assign wr_bus.ready = be_ready && !rd_grant;
   assign wr_bus.rdata = rd_grant ? '0 : be_rdata;

   // A store held off by a refill is still pending afterwards.
   assert property (@(posedge clk_i) disable iff (!arst_n)
      (wr_bus.valid && rd_grant) |=> wr_bus.valid)
      else $error("pending write lost while refill held the bus");

endmodule

//--- verif/be_mem_model.sv
`timescale 1ns/1ns

`include "cache_be_config.svh"

module be_mem_model
   import cache_bus_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        arst_n,
   input  logic                        random_lat, // Zero latency when low.
   input  logic                        be_valid,
   input  logic [`CACHE_BE_ADDR_W-1:0] be_addr,
   input  be_data_t                    be_wdata,
   input  be_strb_t                    be_wstrb,
   output be_data_t                    be_rdata,
   output logic                        be_ready
);

   logic [31:0]                 lcg_state;
   logic [31:0]                 lcg_next;
   logic [1:0]                  wait_q;
   logic [31:0]                 pattern;

   // Accepted writes, oldest first.
   logic [`CACHE_BE_ADDR_W-1:0] log_addr[$];
   be_data_t                    log_data[$];
   be_strb_t                    log_strb[$];

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   assign lcg_next = lcg_step(lcg_state);

   // Latency of the next transfer is drawn when the current one ends.
   always @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
         lcg_state <= 32'd48;
         wait_q    <= '0;
      end else if (be_valid && be_ready) begin
         lcg_state <= lcg_next;
         wait_q    <= random_lat ? lcg_next[17:16] : 2'd0;
         if (be_wstrb != '0) begin
            log_addr.push_back(be_addr);
            log_data.push_back(be_wdata);
            log_strb.push_back(be_wstrb);
         end
      end else if (be_valid && wait_q != 2'd0) begin
         wait_q <= wait_q - 2'd1;
      end
   end

   assign be_ready = be_valid && (wait_q == 2'd0);
   assign pattern  = {8'h00, be_addr};
   assign be_rdata = {pattern, ~pattern}; // Address high, inverse low.

endmodule

//--- verif/tb_cache_back_end.sv
`timescale 1ns/1ns

`include "cache_be_config.svh"

module tb_cache_back_end
   import cache_fe_pkg::*;
   import cache_bus_pkg::*;
();

   // 40 writes and 12 refills at up to 4 cycles per beat is about 400 cycles.
   localparam int TIMEOUT_CYCLES = 2000;
   localparam int N_WRITES = 40;
   localparam int N_REFILLS = 12;

   logic                        clk_i;
   logic                        arst_n;
   logic                        random_lat;
   logic                        write_valid;
   fe_waddr_t                   write_addr;
   fe_word_t                    write_wdata;
   fe_strb_t                    write_wstrb;
   logic                        write_ready;
   logic                        replace_valid;
   line_addr_t                  replace_addr;
   logic                        replace;
   logic                        read_valid;
   beat_idx_t                   read_addr;
   be_data_t                    read_rdata;
   logic                        be_valid;
   logic [`CACHE_BE_ADDR_W-1:0] be_addr;
   be_data_t                    be_wdata;
   be_strb_t                    be_wstrb;
   be_data_t                    be_rdata;
   logic                        be_ready;

   // Expected traffic, oldest first.
   logic [`CACHE_BE_ADDR_W-1:0] exp_wr_addr[$];
   be_data_t                    exp_wr_data[$];
   be_strb_t                    exp_wr_strb[$];
   beat_idx_t                   exp_beat_idx[$];
   be_data_t                    exp_beat_data[$];

   fe_waddr_t                   mix_addr[N_WRITES];
   fe_word_t                    mix_data[N_WRITES];
   fe_strb_t                    mix_strb[N_WRITES];
   int                          mix_wgap[N_WRITES];
   line_addr_t                  mix_line[N_REFILLS];
   int                          mix_rgap[N_REFILLS];

   logic [31:0]                 rand_state = 32'd48;
   int                          cycle_cnt = 0;
   int                          errors = 0;
   int                          tests_run = 0;
   int                          tests_failed = 0;
   int                          bus_writes = 0;
   logic                        order_check = 1'b0; // Refill beats must precede the store.

   function automatic logic [`CACHE_BE_ADDR_W-1:0] write_beat_addr(input fe_waddr_t a);
      return {a, 2'b00};
   endfunction

   function automatic be_data_t write_beat_data(input fe_word_t d);
      return {d, d};
   endfunction

   // Word address bit 0 is byte address bit 2 and picks the upper lane.
   function automatic be_strb_t write_beat_strb(input fe_waddr_t a, input fe_strb_t s);
      return a[0] ? {s, 4'h0} : {4'h0, s};
   endfunction

   function automatic be_data_t refill_beat(input line_addr_t line, input beat_idx_t beat);
      logic [31:0] a;
      a = {8'h00, line, beat, 3'b000};
      return {a, ~a};
   endfunction

   function logic [31:0] next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   cache_back_end UUT (.*);

   be_mem_model mem (.*);

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] got);
      errors++;
      $display("Error: %s expected %h got %h", name, exp, got);
   endtask

   task automatic check_bus_write();
      logic [`CACHE_BE_ADDR_W-1:0] a;
      be_data_t                    d;
      be_strb_t                    s;
      a = mem.log_addr.pop_front();
      d = mem.log_data.pop_front();
      s = mem.log_strb.pop_front();
      bus_writes++;
      if (exp_wr_addr.size() == 0) begin
         errors++;
         $display("A bus write appeared with no store pending");
      end else begin
         if (order_check && exp_beat_idx.size() != 0) begin
            errors++;
            $display("A store reached the bus before the refill had finished");
         end
         if (a !== exp_wr_addr[0])
            report_mismatch("be_addr", 64'(exp_wr_addr[0]), 64'(a));
         if (d !== exp_wr_data[0])
            report_mismatch("be_wdata", exp_wr_data[0], d);
         if (s !== exp_wr_strb[0])
            report_mismatch("be_wstrb", 64'(exp_wr_strb[0]), 64'(s));
         void'(exp_wr_addr.pop_front());
         void'(exp_wr_data.pop_front());
         void'(exp_wr_strb.pop_front());
      end
   endtask

   task automatic check_refill_beat();
      if (exp_beat_idx.size() == 0) begin
         errors++;
         $display("read_valid pulsed with no refill beat pending");
      end else begin
         if (read_addr !== exp_beat_idx[0])
            report_mismatch("read_addr", 64'(exp_beat_idx[0]), 64'(read_addr));
         if (read_rdata !== exp_beat_data[0])
            report_mismatch("read_rdata", exp_beat_data[0], read_rdata);
         if (replace !== (exp_beat_idx[0] != '1)) // Falls with the last beat.
            report_mismatch("replace", 64'(exp_beat_idx[0] != '1), 64'(replace));
         void'(exp_beat_idx.pop_front());
         void'(exp_beat_data.pop_front());
      end
   endtask

   // Outputs are compared half a cycle after the edge.
   always @(negedge clk_i) begin
      if (arst_n) begin
         if (read_valid)
            check_refill_beat();
         while (mem.log_addr.size() != 0)
            check_bus_write();
      end
   end

   task automatic issue_write(input fe_waddr_t a, input fe_word_t d, input fe_strb_t s);
      @(negedge clk_i);
      while (!write_ready)
         @(negedge clk_i);
      exp_wr_addr.push_back(write_beat_addr(a));
      exp_wr_data.push_back(write_beat_data(d));
      exp_wr_strb.push_back(write_beat_strb(a, s));
      @(posedge clk_i);
      write_valid <= 1'b1;
      write_addr  <= a;
      write_wdata <= d;
      write_wstrb <= s;
      @(posedge clk_i);
      write_valid <= 1'b0;
   endtask

   task automatic issue_refill(input line_addr_t line);
      @(negedge clk_i);
      while (replace)
         @(negedge clk_i);
      for (int b = 0; b < 4; b++) begin
         exp_beat_idx.push_back(beat_idx_t'(b));
         exp_beat_data.push_back(refill_beat(line, beat_idx_t'(b)));
      end
      @(posedge clk_i);
      replace_valid <= 1'b1;
      replace_addr  <= line;
      @(posedge clk_i);
      replace_valid <= 1'b0;
   endtask

   task automatic wait_idle();
      @(negedge clk_i);
      while (!write_ready || replace || exp_wr_addr.size() != 0 || exp_beat_idx.size() != 0)
         @(negedge clk_i);
   endtask

   task automatic end_test(input string name, input int err_before);
      wait_idle();
      tests_run++;
      if (errors == err_before) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
      end
   endtask

   initial begin
      int          err_before;
      int          n;
      logic [31:0] r;
      arst_n        = 1'b0;
      random_lat    = 1'b0;
      write_valid   = 1'b0;
      write_addr    = '0;
      write_wdata   = '0;
      write_wstrb   = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      repeat (3) @(posedge clk_i);
      arst_n <= 1'b1;

      err_before = errors;
      @(negedge clk_i);
      if (write_ready !== 1'b1)
         report_mismatch("write_ready", 64'd1, 64'(write_ready));
      if (replace !== 1'b0)
         report_mismatch("replace", 64'd0, 64'(replace));
      if (read_valid !== 1'b0)
         report_mismatch("read_valid", 64'd0, 64'(read_valid));
      if (be_valid !== 1'b0)
         report_mismatch("be_valid", 64'd0, 64'(be_valid));
      end_test("reset state", err_before);

      err_before = errors;
      n = bus_writes;
      issue_write(22'h012345, 32'hdeadbeef, 4'b0110);
      wait_idle();
      if (bus_writes - n != 1) begin
         errors++;
         $display("One store gave %0d bus writes", bus_writes - n);
      end
      end_test("single write", err_before);

      err_before = errors;
      issue_refill(19'h0abcd);
      end_test("line refill", err_before);

      err_before = errors;
      @(posedge clk_i);
      random_lat <= 1'b1;
      for (int i = 0; i < 4; i++) begin
         r = next_rand();
         issue_write(r[29:8], next_rand(), (r[3:0] == 4'h0) ? 4'hf : r[3:0]);
         r = next_rand();
         issue_refill(r[31:13]);
      end
      end_test("random latency", err_before);

      err_before = errors;
      order_check = 1'b1;
      fork
         issue_write(22'h2aaaa9, 32'h0badcafe, 4'b1001);
         issue_refill(19'h15555);
      join
      end_test("refill before pending write", err_before);
      order_check = 1'b0;

      err_before = errors;
      for (int i = 0; i < N_WRITES; i++) begin
         r           = next_rand();
         mix_addr[i] = r[31:10];
         mix_strb[i] = (r[7:4] == 4'h0) ? 4'hf : r[7:4];
         mix_data[i] = next_rand();
         mix_wgap[i] = int'(r[9:8]);
      end
      for (int i = 0; i < N_REFILLS; i++) begin
         r           = next_rand();
         mix_line[i] = r[31:13];
         mix_rgap[i] = int'(r[11:8]);
      end
      fork
         for (int i = 0; i < N_WRITES; i++) begin
            repeat (mix_wgap[i]) @(posedge clk_i);
            issue_write(mix_addr[i], mix_data[i], mix_strb[i]);
         end
         for (int i = 0; i < N_REFILLS; i++) begin
            repeat (mix_rgap[i]) @(posedge clk_i);
            issue_refill(mix_line[i]);
         end
      join
      end_test("random mix", err_before);

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- cache_back_end.f
+incdir+hdl
hdl/cache_fe_pkg.sv
hdl/cache_bus_pkg.sv
hdl/be_bus_if.sv
hdl/cache_write_channel.sv
hdl/cache_read_channel.sv
hdl/cache_back_end.sv
verif/be_mem_model.sv
verif/tb_cache_back_end.sv

//--- Makefile
TOP = tb_cache_back_end

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal -f cache_back_end.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only --timing --assert -f cache_back_end.f --top-module $(TOP)

clean:
	rm -rf obj_dir
